// File: hdl/fp_format_pkg.sv
/*
 * FP32 field layout and the encodings shared by every floating-point block.
 * Holds the operand class flags, the status flags and the one-hot class mask.
 * Import it wherever a raw FP32 word is taken apart or a flag is produced.
 */
package fp_format_pkg;

  // ----------------------------------------------------------------------
  // Field widths
  // ----------------------------------------------------------------------
  localparam int unsigned EXP_BITS = 8;
  localparam int unsigned MAN_BITS = 23;
  localparam int unsigned FP_WIDTH = 1 + EXP_BITS + MAN_BITS;

  // IEEE 754 single precision word, sign in the MSB
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp32_t;

  // Canonical quiet NaN
  // Positive, exponent saturated, only the mantissa MSB set
  localparam fp32_t QNAN_CANON = '{
    sign:     1'b0,
    exponent: '1,
    mantissa: {1'b1, {(MAN_BITS-1){1'b0}}}
  };

  // Operand class flags from the decode step
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_quiet;
  } fp_info_t;

  // Exception flags in the usual RISC-V fflags order
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // ----------------------------------------------------------------------
  // One-hot classification mask
  // ----------------------------------------------------------------------
  typedef enum logic [9:0] {
    NEGINF     = 10'h001,
    NEGNORM    = 10'h002,
    NEGSUBNORM = 10'h004,
    NEGZERO    = 10'h008,
    POSZERO    = 10'h010,
    POSSUBNORM = 10'h020,
    POSNORM    = 10'h040,
    POSINF     = 10'h080,
    SNAN       = 10'h100,
    QNAN       = 10'h200
  } classmask_e;

endpackage

// File: hdl/fp_noncomp_pkg.sv
/*
 * Operation encodings and the structs that carry an operation through the
 * non-computational FP unit, from request to response.
 * The rm field of the instruction doubles as the sub-operation select.
 */
package fp_noncomp_pkg;

  import fp_format_pkg::*;

  // ----------------------------------------------------------------------
  // Operation encodings
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    SGNJ     = 2'd0,
    MINMAX   = 2'd1,
    CMP      = 2'd2,
    CLASSIFY = 2'd3
  } operation_e;

  // Sub-operation carried in the rm field
  // RNE selects SGNJ or MIN or LE
  // RTZ selects SGNJN or MAX or LT
  // RDN selects SGNJX or EQ
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } roundmode_e;

  localparam int unsigned TAG_BITS = 8;

  typedef logic [TAG_BITS-1:0] tag_t;

  // ----------------------------------------------------------------------
  // Pipeline payloads
  // ----------------------------------------------------------------------
  // Request as seen on the input handshake
  typedef struct packed {
    fp32_t      operand_a;
    fp32_t      operand_b;
    roundmode_e rnd_mode;
    operation_e op;
    logic       op_mod;
    tag_t       tag;
  } fp_noncomp_req_t;

  // Request plus everything the execute units derive from the operands
  typedef struct packed {
    fp_noncomp_req_t req;
    fp_info_t        info_a;
    fp_info_t        info_b;
    logic            a_smaller;
    logic            operands_equal;
    logic            any_nan;
    logic            any_snan;
  } fp_decoded_t;

  // One execute lane result
  typedef struct packed {
    fp32_t   value;
    status_t status;
    logic    extension_bit;
  } fp_lane_t;

  // Response as seen on the output handshake
  typedef struct packed {
    fp32_t      result;
    status_t    status;
    logic       extension_bit;
    classmask_e class_mask;
    logic       is_class;
    tag_t       tag;
  } fp_noncomp_rsp_t;

endpackage

// File: hdl/fp_pipe_stage.sv
/*
 * Single valid/ready register slice with a payload of any packed type.
 * Ready to upstream is combinational, so an empty stage always accepts and
 * a full stage accepts only when downstream takes its item this cycle.
 */
`timescale 1ns/1ps

module fp_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Advance when downstream takes the item or the slot holds a bubble
  assign ready_o = ready_i | ~valid_q;

  // Valid bit follows upstream whenever the stage advances
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves on an accepted transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// File: hdl/fp_operand_decode.sv
/*
 * Combinational operand decode for the non-computational FP unit.
 * Classifies both operands and derives the ordering and NaN summaries that
 * the min/max, compare and sign/class units all share.
 */
`timescale 1ns/1ps

module fp_operand_decode
  import fp_format_pkg::*;
  import fp_noncomp_pkg::*;
(
  input  fp_noncomp_req_t req_i,
  output fp_decoded_t     dec_o
);

  // ----------------------------------------------------------------------
  // Operand classification
  // ----------------------------------------------------------------------
  function automatic fp_info_t classify_operand(input fp32_t op);
    fp_info_t info;
    logic     exp_zero;
    logic     exp_ones;
    logic     man_zero;
    exp_zero = (op.exponent == '0);
    exp_ones = (op.exponent == '1);
    man_zero = (op.mantissa == '0);
    info.is_normal     = !exp_zero && !exp_ones;
    info.is_subnormal  = exp_zero && !man_zero;
    info.is_zero       = exp_zero && man_zero;
    info.is_inf        = exp_ones && man_zero;
    info.is_nan        = exp_ones && !man_zero;
    // Quiet NaNs carry the mantissa MSB
    info.is_signalling = info.is_nan && !op.mantissa[MAN_BITS-1];
    info.is_quiet      = info.is_nan && op.mantissa[MAN_BITS-1];
    return info;
  endfunction

  fp_info_t            info_a;
  fp_info_t            info_b;
  logic [FP_WIDTH-1:0] bits_a;
  logic [FP_WIDTH-1:0] bits_b;

  assign info_a = classify_operand(req_i.operand_a);
  assign info_b = classify_operand(req_i.operand_b);

  // Raw words for the magnitude compare
  assign bits_a = req_i.operand_a;
  assign bits_b = req_i.operand_b;

  // ----------------------------------------------------------------------
  // Ordering and NaN summaries
  // ----------------------------------------------------------------------
  assign dec_o.req    = req_i;
  assign dec_o.info_a = info_a;
  assign dec_o.info_b = info_b;

  // Bit equality or any pair of zeros regardless of sign
  assign dec_o.operands_equal = (bits_a == bits_b) || (info_a.is_zero && info_b.is_zero);

  // Sign-magnitude order through an unsigned compare
  // A set sign on either side flips the outcome
  assign dec_o.a_smaller = (bits_a < bits_b) ^
                           (req_i.operand_a.sign || req_i.operand_b.sign);

  assign dec_o.any_nan  = info_a.is_nan || info_b.is_nan;
  assign dec_o.any_snan = info_a.is_signalling || info_b.is_signalling;

endmodule

// File: hdl/fp_compare_unit.sv
/*
 * Min/max and compare lanes of the non-computational FP unit.
 * Purely combinational. The sub-operation comes from the rm field and
 * op_mod inverts the boolean compare outcome.
 */
`timescale 1ns/1ps

module fp_compare_unit
  import fp_format_pkg::*;
  import fp_noncomp_pkg::*;
(
  input  fp_decoded_t dec_i,
  output fp_lane_t    minmax_o,
  output fp_lane_t    cmp_o
);

  fp32_t      op_a;
  fp32_t      op_b;
  roundmode_e sub_op;
  logic       op_mod;

  assign op_a   = dec_i.req.operand_a;
  assign op_b   = dec_i.req.operand_b;
  assign sub_op = dec_i.req.rnd_mode;
  assign op_mod = dec_i.req.op_mod;

  // ----------------------------------------------------------------------
  // Minimum and maximum
  // ----------------------------------------------------------------------
  always_comb begin : min_max
    minmax_o.status    = '0;
    // Quiet comparison so only sNaN inputs are invalid
    minmax_o.status.NV = dec_i.any_snan;
    // Always a float result
    minmax_o.extension_bit = 1'b1;
    if (dec_i.info_a.is_nan && dec_i.info_b.is_nan) begin
      minmax_o.value = QNAN_CANON;
    end else if (dec_i.info_a.is_nan) begin
      minmax_o.value = op_b;
    end else if (dec_i.info_b.is_nan) begin
      minmax_o.value = op_a;
    end else if (sub_op == RTZ) begin
      // MAX
      minmax_o.value = dec_i.a_smaller ? op_b : op_a;
    end else begin
      // MIN
      minmax_o.value = dec_i.a_smaller ? op_a : op_b;
    end
  end

  // ----------------------------------------------------------------------
  // Comparisons
  // ----------------------------------------------------------------------
  logic    cmp_bit;
  status_t cmp_status;

  always_comb begin : compare
    cmp_bit    = 1'b0;
    cmp_status = '0;
    if (dec_i.any_snan) begin
      // Invalid for every compare
      // Only an inverted EQ reports true
      cmp_status.NV = 1'b1;
      cmp_bit       = (sub_op == RDN) && op_mod;
    end else begin
      case (sub_op)
        // LE is a signalling compare
        RNE: begin
          if (dec_i.any_nan) begin
            cmp_status.NV = 1'b1;
          end else begin
            cmp_bit = (dec_i.a_smaller | dec_i.operands_equal) ^ op_mod;
          end
        end
        // LT is a signalling compare too
        RTZ: begin
          if (dec_i.any_nan) begin
            cmp_status.NV = 1'b1;
          end else begin
            cmp_bit = (dec_i.a_smaller & ~dec_i.operands_equal) ^ op_mod;
          end
        end
        // EQ stays quiet and a NaN never equals anything
        RDN: begin
          cmp_bit = dec_i.any_nan ? op_mod : (dec_i.operands_equal ^ op_mod);
        end
        default: cmp_bit = 1'b0;
      endcase
    end
  end

  // Boolean result in bit 0 for the integer register file
  assign cmp_o.value         = fp32_t'({{(FP_WIDTH-1){1'b0}}, cmp_bit});
  assign cmp_o.status        = cmp_status;
  assign cmp_o.extension_bit = 1'b0;

endmodule

// File: hdl/fp_sign_class_unit.sv
/*
 * Sign injection and classification lanes of the non-computational FP unit.
 * Purely combinational. Sign injection rebuilds operand a with a new sign
 * and classification reports operand a as a one-hot class mask.
 */
`timescale 1ns/1ps

module fp_sign_class_unit
  import fp_format_pkg::*;
  import fp_noncomp_pkg::*;
(
  input  fp_decoded_t dec_i,
  output fp_lane_t    sgnj_o,
  output classmask_e  class_mask_o
);

  fp32_t    op_a;
  fp_info_t info_a;
  logic     sign_b;

  assign op_a   = dec_i.req.operand_a;
  assign info_a = dec_i.info_a;
  assign sign_b = dec_i.req.operand_b.sign;

  // ----------------------------------------------------------------------
  // Sign injection
  // ----------------------------------------------------------------------
  fp32_t sgnj_value;

  always_comb begin : sign_inject
    // Exponent and mantissa always from operand a
    sgnj_value = op_a;
    case (dec_i.req.rnd_mode)
      RNE:     sgnj_value.sign = sign_b;
      RTZ:     sgnj_value.sign = ~sign_b;
      RDN:     sgnj_value.sign = op_a.sign ^ sign_b;
      default: sgnj_value.sign = op_a.sign;
    endcase
  end

  assign sgnj_o.value  = sgnj_value;
  // Never raises a flag
  assign sgnj_o.status = '0;
  // op_mod asks for integer sign extension of the result
  assign sgnj_o.extension_bit = dec_i.req.op_mod ? sgnj_value.sign : 1'b1;

  // ----------------------------------------------------------------------
  // Classification
  // ----------------------------------------------------------------------
  always_comb begin : classify
    if (info_a.is_normal) begin
      class_mask_o = op_a.sign ? NEGNORM : POSNORM;
    end else if (info_a.is_subnormal) begin
      class_mask_o = op_a.sign ? NEGSUBNORM : POSSUBNORM;
    end else if (info_a.is_zero) begin
      class_mask_o = op_a.sign ? NEGZERO : POSZERO;
    end else if (info_a.is_inf) begin
      class_mask_o = op_a.sign ? NEGINF : POSINF;
    end else if (info_a.is_quiet) begin
      class_mask_o = QNAN;
    end else begin
      // Only a signalling NaN is left
      class_mask_o = SNAN;
    end
  end

endmodule

// File: hdl/fp_result_select.sv
/*
 * Result selection for the non-computational FP unit.
 * Picks the execute lane named by the operation and packs the response
 * that goes into the output register stage.
 */
`timescale 1ns/1ps

module fp_result_select
  import fp_format_pkg::*;
  import fp_noncomp_pkg::*;
(
  input  fp_decoded_t     dec_i,
  input  fp_lane_t        sgnj_i,
  input  fp_lane_t        minmax_i,
  input  fp_lane_t        cmp_i,
  input  classmask_e      class_mask_i,
  output fp_noncomp_rsp_t rsp_o
);

  fp_lane_t lane;

  // ----------------------------------------------------------------------
  // Lane multiplexer
  // ----------------------------------------------------------------------
  always_comb begin : select_lane
    case (dec_i.req.op)
      SGNJ:   lane = sgnj_i;
      MINMAX: lane = minmax_i;
      CMP:    lane = cmp_i;
      // Classification answers on the class mask only
      // Result and flags read as zero
      CLASSIFY: begin
        lane = '0;
      end
      default: lane = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Response packing
  // ----------------------------------------------------------------------
  assign rsp_o.result        = lane.value;
  assign rsp_o.status        = lane.status;
  assign rsp_o.extension_bit = lane.extension_bit;

  // Mask always travels and is_class tells the consumer to use it
  assign rsp_o.class_mask = class_mask_i;
  assign rsp_o.is_class   = (dec_i.req.op == CLASSIFY);

  // Tag rides along unchanged
  assign rsp_o.tag = dec_i.req.tag;

endmodule

// File: hdl/fp_noncomp_top.sv
/*
 * Top level of the pipelined FP32 non-computational unit.
 * One register stage before the combinational logic and one after it.
 * Requests enter on a valid/ready handshake and leave in order with tags.
 */
`timescale 1ns/1ps

module fp_noncomp_top
  import fp_format_pkg::*;
  import fp_noncomp_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  // Input handshake
  input  fp_noncomp_req_t req_i,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  // Output handshake
  output fp_noncomp_rsp_t rsp_o,
  output logic            out_valid_o,
  input  logic            out_ready_i,
  // High while any stage holds an operation
  output logic            busy_o
);

  fp_noncomp_req_t req_q;
  logic            req_valid;
  logic            rsp_ready;
  fp_decoded_t     dec;
  fp_lane_t        sgnj_lane;
  fp_lane_t        minmax_lane;
  fp_lane_t        cmp_lane;
  classmask_e      class_mask;
  fp_noncomp_rsp_t rsp_d;

  // ----------------------------------------------------------------------
  // Input register stage
  // ----------------------------------------------------------------------
  fp_pipe_stage #(
    .payload_t ( fp_noncomp_req_t )
  ) i_in_stage (
    .clk_i   ( clk_i      ),
    .rst_i   ( rst_i      ),
    .valid_i ( in_valid_i ),
    .ready_o ( in_ready_o ),
    .data_i  ( req_i      ),
    .valid_o ( req_valid  ),
    .ready_i ( rsp_ready  ),
    .data_o  ( req_q      )
  );

  // ----------------------------------------------------------------------
  // Combinational decode and execute
  // ----------------------------------------------------------------------
  fp_operand_decode i_decode (
    .req_i ( req_q ),
    .dec_o ( dec   )
  );

  fp_compare_unit i_compare (
    .dec_i    ( dec         ),
    .minmax_o ( minmax_lane ),
    .cmp_o    ( cmp_lane    )
  );

  fp_sign_class_unit i_sign_class (
    .dec_i        ( dec        ),
    .sgnj_o       ( sgnj_lane  ),
    .class_mask_o ( class_mask )
  );

  fp_result_select i_select (
    .dec_i        ( dec         ),
    .sgnj_i       ( sgnj_lane   ),
    .minmax_i     ( minmax_lane ),
    .cmp_i        ( cmp_lane    ),
    .class_mask_i ( class_mask  ),
    .rsp_o        ( rsp_d       )
  );

  // ----------------------------------------------------------------------
  // Output register stage
  // ----------------------------------------------------------------------
  fp_pipe_stage #(
    .payload_t ( fp_noncomp_rsp_t )
  ) i_out_stage (
    .clk_i   ( clk_i       ),
    .rst_i   ( rst_i       ),
    .valid_i ( req_valid   ),
    .ready_o ( rsp_ready   ),
    .data_i  ( rsp_d       ),
    .valid_o ( out_valid_o ),
    .ready_i ( out_ready_i ),
    .data_o  ( rsp_o       )
  );

  assign busy_o = req_valid | out_valid_o;

endmodule

// File: include/tb_fp_noncomp_vectors.svh
/*
 * Stimulus and expected results for the FP32 non-computational unit.
 * Included inside the testbench module, where load_vectors fills the table.
 * Each row gives op, sub-op, op_mod, operand a, operand b, result, NV, ext and class of a
 */
`ifndef TB_FP_NONCOMP_VECTORS_SVH
`define TB_FP_NONCOMP_VECTORS_SVH

task automatic load_vectors();
  // --------------------------------------------------------------------
  // Sign injection
  // --------------------------------------------------------------------
  // Ext is 1 without op_mod and the result sign with it
  add_vector(SGNJ, RNE, 0, 32'h3F800000, 32'hC0000000, 32'hBF800000, 0, 1, POSNORM);
  add_vector(SGNJ, RTZ, 0, 32'h3F800000, 32'hC0000000, 32'h3F800000, 0, 1, POSNORM);
  add_vector(SGNJ, RDN, 0, 32'hBF800000, 32'hC0000000, 32'h3F800000, 0, 1, NEGNORM);
  add_vector(SGNJ, RNE, 1, 32'h40000000, 32'hBF800000, 32'hC0000000, 0, 1, POSNORM);
  add_vector(SGNJ, RTZ, 1, 32'hC0400000, 32'hBF800000, 32'h40400000, 0, 0, NEGNORM);
  add_vector(SGNJ, RDN, 1, 32'h3FC00000, 32'h80000000, 32'hBFC00000, 0, 1, POSNORM);
  // NaN payload kept, only the sign moves
  add_vector(SGNJ, RNE, 0, 32'h7FC00000, 32'h80000000, 32'hFFC00000, 0, 1, QNAN);

  // --------------------------------------------------------------------
  // Min and max
  // --------------------------------------------------------------------
  add_vector(MINMAX, RNE, 0, 32'h3F800000, 32'h40000000, 32'h3F800000, 0, 1, POSNORM);
  add_vector(MINMAX, RTZ, 0, 32'h3F800000, 32'h40000000, 32'h40000000, 0, 1, POSNORM);
  add_vector(MINMAX, RNE, 0, 32'hBF800000, 32'hC0000000, 32'hC0000000, 0, 1, NEGNORM);
  add_vector(MINMAX, RTZ, 0, 32'hBF800000, 32'h3F800000, 32'h3F800000, 0, 1, NEGNORM);
  // -0 orders below +0
  add_vector(MINMAX, RNE, 0, 32'h00000000, 32'h80000000, 32'h80000000, 0, 1, POSZERO);
  add_vector(MINMAX, RTZ, 0, 32'h80000000, 32'h00000000, 32'h00000000, 0, 1, NEGZERO);
  // Single quiet NaN yields the other operand
  add_vector(MINMAX, RNE, 0, 32'h7FC00000, 32'h3F800000, 32'h3F800000, 0, 1, QNAN);
  add_vector(MINMAX, RTZ, 0, 32'hC0000000, 32'h7FC00000, 32'hC0000000, 0, 1, NEGNORM);
  // Two NaNs give the canonical NaN
  add_vector(MINMAX, RNE, 0, 32'h7FC00000, 32'hFFC00001, 32'h7FC00000, 0, 1, QNAN);
  add_vector(MINMAX, RTZ, 0, 32'h7F800001, 32'h40000000, 32'h40000000, 1, 1, SNAN);
  add_vector(MINMAX, RNE, 0, 32'h7FC00000, 32'h7F800001, 32'h7FC00000, 1, 1, QNAN);

  // --------------------------------------------------------------------
  // Compares
  // --------------------------------------------------------------------
  // Sub-op RNE is LE while RTZ is LT and RDN is EQ
  add_vector(CMP, RNE, 0, 32'h3F800000, 32'h40000000, 32'h00000001, 0, 0, POSNORM);
  add_vector(CMP, RNE, 0, 32'h40000000, 32'h3F800000, 32'h00000000, 0, 0, POSNORM);
  add_vector(CMP, RNE, 1, 32'h3F800000, 32'h40000000, 32'h00000000, 0, 0, POSNORM);
  add_vector(CMP, RTZ, 0, 32'h3F800000, 32'h3F800000, 32'h00000000, 0, 0, POSNORM);
  add_vector(CMP, RTZ, 0, 32'hC0000000, 32'hBF800000, 32'h00000001, 0, 0, NEGNORM);
  add_vector(CMP, RTZ, 1, 32'hC0000000, 32'hBF800000, 32'h00000000, 0, 0, NEGNORM);
  add_vector(CMP, RDN, 0, 32'h00000000, 32'h80000000, 32'h00000001, 0, 0, POSZERO);
  add_vector(CMP, RDN, 1, 32'h3F800000, 32'h40000000, 32'h00000001, 0, 0, POSNORM);
  // Quiet NaN in LE and LT is invalid while EQ stays quiet
  add_vector(CMP, RNE, 0, 32'h7FC00000, 32'h3F800000, 32'h00000000, 1, 0, QNAN);
  add_vector(CMP, RTZ, 1, 32'h3F800000, 32'h7FC00000, 32'h00000000, 1, 0, POSNORM);
  add_vector(CMP, RDN, 0, 32'h3F800000, 32'h7FC00000, 32'h00000000, 0, 0, POSNORM);
  add_vector(CMP, RDN, 1, 32'h7FC00000, 32'h3F800000, 32'h00000001, 0, 0, QNAN);
  // Signalling NaN always invalid
  add_vector(CMP, RDN, 0, 32'h7F800001, 32'h7F800001, 32'h00000000, 1, 0, SNAN);
  add_vector(CMP, RDN, 1, 32'h3F800000, 32'h7F800001, 32'h00000001, 1, 0, POSNORM);
  add_vector(CMP, RNE, 1, 32'h7F800001, 32'h3F800000, 32'h00000000, 1, 0, SNAN);
  // Zeros of either sign compare equal
  add_vector(CMP, RNE, 0, 32'h80000000, 32'h00000000, 32'h00000001, 0, 0, NEGZERO);
  add_vector(CMP, RTZ, 0, 32'h00000000, 32'h80000000, 32'h00000000, 0, 0, POSZERO);

  // --------------------------------------------------------------------
  // Classification of all ten classes
  // --------------------------------------------------------------------
  add_vector(CLASSIFY, RNE, 0, 32'hFF800000, 32'h00000000, 32'h00000000, 0, 0, NEGINF);
  add_vector(CLASSIFY, RNE, 0, 32'hBF800000, 32'h00000000, 32'h00000000, 0, 0, NEGNORM);
  add_vector(CLASSIFY, RNE, 0, 32'h80000001, 32'h00000000, 32'h00000000, 0, 0, NEGSUBNORM);
  add_vector(CLASSIFY, RNE, 0, 32'h80000000, 32'h00000000, 32'h00000000, 0, 0, NEGZERO);
  add_vector(CLASSIFY, RNE, 0, 32'h00000000, 32'h00000000, 32'h00000000, 0, 0, POSZERO);
  add_vector(CLASSIFY, RNE, 0, 32'h00000001, 32'h00000000, 32'h00000000, 0, 0, POSSUBNORM);
  add_vector(CLASSIFY, RNE, 0, 32'h3F800000, 32'h00000000, 32'h00000000, 0, 0, POSNORM);
  add_vector(CLASSIFY, RNE, 0, 32'h7F800000, 32'h00000000, 32'h00000000, 0, 0, POSINF);
  add_vector(CLASSIFY, RNE, 0, 32'h7F800001, 32'h00000000, 32'h00000000, 0, 0, SNAN);
  add_vector(CLASSIFY, RNE, 0, 32'h7FC00000, 32'h00000000, 32'h00000000, 0, 0, QNAN);
endtask

`endif

// File: testbench/tb_fp_noncomp.sv
/*
 * Testbench for the pipelined FP32 non-computational unit.
 * Streams the vector table through the DUT with random idle gaps and random
 * output back-pressure, and checks every response in order with its tag.
 */
`timescale 1ns/1ps

module tb_fp_noncomp
  import fp_format_pkg::*;
  import fp_noncomp_pkg::*;
;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;

  // One table row whose tag the driver fills in
  typedef struct packed {
    fp_noncomp_req_t req;
    fp_lane_t        lane;
    classmask_e      mask;
    logic            is_class;
  } vector_t;

  logic            clk_i;
  logic            rst_i;
  fp_noncomp_req_t req_i;
  logic            in_valid_i;
  logic            in_ready_o;
  fp_noncomp_rsp_t rsp_o;
  logic            out_valid_o;
  logic            out_ready_i;
  logic            busy_o;

  vector_t     vectors[$];
  vector_t     expected[$];
  int          num_rows;
  int          received_count;
  bit          vectors_loaded;

  `include "tb_fp_noncomp_vectors.svh"

  fp_noncomp_top i_dut (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .req_i       ( req_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .rsp_o       ( rsp_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // Table building and failure reporting
  // ----------------------------------------------------------------------
  task automatic add_vector(input operation_e op, input roundmode_e rm, input logic op_mod,
                            input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] result, input logic nv, input logic ext,
                            input classmask_e mask);
    vector_t row;
    row                    = '0;
    row.req.operand_a      = a;
    row.req.operand_b      = b;
    row.req.rnd_mode       = rm;
    row.req.op             = op;
    row.req.op_mod         = op_mod;
    row.lane.value         = result;
    row.lane.status.NV     = nv;
    row.lane.extension_bit = ext;
    row.mask               = mask;
    // Only a classify answers on the mask
    row.is_class           = (op == CLASSIFY);
    vectors.push_back(row);
  endtask

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    stop_with_failure();
  endtask

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_lane(input fp_noncomp_rsp_t got, input fp_lane_t exp);
    if (got.result !== exp.value)
      report_mismatch($sformatf("tag %0d result %h, expected %h", got.tag, got.result,
                                exp.value));
    if (got.status !== exp.status)
      report_mismatch($sformatf("tag %0d status %b, expected %b", got.tag, got.status,
                                exp.status));
    if (got.extension_bit !== exp.extension_bit)
      report_mismatch($sformatf("tag %0d extension bit %b, expected %b", got.tag,
                                got.extension_bit, exp.extension_bit));
  endtask

  // Mask of operand a travels with every response
  task automatic check_class(input fp_noncomp_rsp_t got, input classmask_e exp_mask,
                             input logic exp_is_class);
    if (got.is_class !== exp_is_class)
      report_mismatch($sformatf("tag %0d is_class %b, expected %b", got.tag, got.is_class,
                                exp_is_class));
    if (got.class_mask !== exp_mask)
      report_mismatch($sformatf("tag %0d class mask %h, expected %h", got.tag,
                                got.class_mask, exp_mask));
  endtask

  task automatic check_tag(input tag_t got, input tag_t exp);
    if (got !== exp)
      report_mismatch($sformatf("tag %0d, expected %0d", got, exp));
  endtask

  task automatic expect_level(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  // Stalled response must not move
  task automatic verify_stall_hold(input fp_noncomp_rsp_t got, input fp_noncomp_rsp_t held);
    if (got !== held)
      report_mismatch($sformatf("response changed while stalled, tag %0d was %0d", got.tag,
                                held.tag));
  endtask

  // ----------------------------------------------------------------------
  // Driver
  // ----------------------------------------------------------------------
  initial begin : driver
    vector_t row;
    int      idx;
    int      gap;
    logic    accepted;
    rst_i          = 1'b1;
    in_valid_i     = 1'b0;
    req_i          = '0;
    out_ready_i    = 1'b0;
    received_count = 0;
    vectors_loaded = 1'b0;
    void'($urandom(32'h329fb264));
    load_vectors();
    num_rows       = vectors.size();
    vectors_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    expect_level(out_valid_o, 1'b0, "out_valid_o after reset");
    expect_level(busy_o, 1'b0, "busy_o after reset");
    expect_level(in_ready_o, 1'b1, "in_ready_o after reset");
    rst_i = 1'b0;
    for (idx = 0; idx < num_rows; idx++) begin
      gap = $urandom_range(0, 2);
      repeat (gap) begin
        in_valid_i = 1'b0;
        @(negedge clk_i);
      end
      row         = vectors[idx];
      row.req.tag = tag_t'(idx);
      req_i       = row.req;
      in_valid_i  = 1'b1;
      accepted    = 1'b0;
      // Hold the row until the DUT takes it
      while (!accepted) begin
        #(CLK_PERIOD / 4);
        if (in_ready_o) begin
          accepted = 1'b1;
          expected.push_back(row);
        end
        @(negedge clk_i);
      end
    end
    in_valid_i = 1'b0;
    wait (received_count == num_rows);
    @(negedge clk_i);
    expect_level(busy_o, 1'b0, "busy_o after last response");
    expect_level(out_valid_o, 1'b0, "out_valid_o after last response");
    $display("Test completed successfully");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Monitor with random back-pressure
  // ----------------------------------------------------------------------
  initial begin : monitor
    vector_t         exp_row;
    fp_noncomp_rsp_t held_rsp;
    logic            held;
    held     = 1'b0;
    held_rsp = '0;
    wait (rst_i === 1'b0);
    forever begin
      @(negedge clk_i);
      if (held) begin
        expect_level(out_valid_o, 1'b1, "out_valid_o under back-pressure");
        verify_stall_hold(rsp_o, held_rsp);
      end
      // A waiting response keeps the unit busy
      if (out_valid_o) begin
        expect_level(busy_o, 1'b1, "busy_o while a response waits");
      end
      out_ready_i = ($urandom_range(0, 3) != 0);
      if (out_valid_o && out_ready_i) begin
        if (expected.size() == 0) begin
          $display("Response with tag %0d arrived with nothing outstanding", rsp_o.tag);
          stop_with_failure();
        end
        exp_row = expected.pop_front();
        check_lane(rsp_o, exp_row.lane);
        check_class(rsp_o, exp_row.mask, exp_row.is_class);
        check_tag(rsp_o.tag, exp_row.req.tag);
        received_count++;
      end
      held     = out_valid_o && !out_ready_i;
      held_rsp = rsp_o;
    end
  end

  // Bound scales with the table at six cycles per row plus margin
  initial begin : watchdog
    wait (vectors_loaded);
    repeat (num_rows * 6 + 50) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d clock periods", num_rows * 6 + 50);
    stop_with_failure();
  end

endmodule

// File: tb.f
+incdir+include
hdl/fp_format_pkg.sv
hdl/fp_noncomp_pkg.sv
hdl/fp_pipe_stage.sv
hdl/fp_operand_decode.sv
hdl/fp_compare_unit.sv
hdl/fp_sign_class_unit.sv
hdl/fp_result_select.sv
hdl/fp_noncomp_top.sv
testbench/tb_fp_noncomp.sv
